// ==== common/plca_pkg.sv ====
package plca_pkg;

    localparam int NIBBLE_W      = 4;                 // MII data nibble width.
    localparam int MII_W         = NIBBLE_W + 2;      // Nibble plus the enable and error flags.
    localparam int NODE_ID_W     = 8;                 // Node IDs, node count and curID.

    localparam int TO_CYCLES     = 32;                // Length of an idle transmit opportunity.
    localparam int BEACON_CYCLES = 20;                // Length of a BEACON sent by the coordinator.
    localparam int TIMER_W       = 6;                 // Wide enough for both timers above.

    localparam int DELAY_DEPTH   = 64;                // Delay-line depth in nibbles.
    localparam int DELAY_ADDR_W  = 6;                 // Address width of the delay line.

    // Indication codes carried on the nibble with the enable low and the error flag high.
    localparam logic [NIBBLE_W-1:0] BEACON_CODE = 4'b0010;
    localparam logic [NIBBLE_W-1:0] COMMIT_CODE = 4'b0011;

    // Full 6-bit words as seen on {RX_DV, RX_ER, RXD}.
    localparam logic [MII_W-1:0] BEACON_IND = {1'b0, 1'b1, BEACON_CODE};
    localparam logic [MII_W-1:0] COMMIT_IND = {1'b0, 1'b1, COMMIT_CODE};

    // Opportunity FSM state encodings.
    localparam int              ST_W        = 3;
    localparam logic [ST_W-1:0] ST_IDLE     = 3'd0;   // Entered from reset or with PLCA off.
    localparam logic [ST_W-1:0] ST_BEACON   = 3'd1;   // Coordinator is sending a BEACON.
    localparam logic [ST_W-1:0] ST_WAIT_BCN = 3'd2;   // Follower waits for a received BEACON.
    localparam logic [ST_W-1:0] ST_RX_BCN   = 3'd3;   // A received BEACON is in progress.
    localparam logic [ST_W-1:0] ST_OPP      = 3'd4;   // Opportunity running with no carrier yet.
    localparam logic [ST_W-1:0] ST_OPP_BUSY = 3'd5;   // Opportunity taken, waits for carrier off.

    // One MII word. The control block compares the flat code against whole indications,
    // while the field view picks out the enable flag and lets the mux build its outputs.
    typedef union packed {
        struct packed {
            logic                en;                  // TX_EN or RX_DV.
            logic                er;                  // TX_ER or RX_ER.
            logic [NIBBLE_W-1:0] nib;                 // TXD or RXD.
        } f;
        logic [MII_W-1:0] code;
    } mii_word_u;

endpackage

// ==== common/txop_if.sv ====
`timescale 1ns/10ps

interface txop_if;
    import plca_pkg::*;

    logic [NODE_ID_W-1:0] cur_id;                     // Number of the running opportunity.
    logic                 beacon;                     // High while this node sends a BEACON.
    logic                 my_turn;                    // High during this node's own opportunity.
    logic                 tx_busy;                    // High while buffered data goes out.

    // The control block owns the cycle state and watches the delay line.
    modport ctrl (
        output cur_id,
        output beacon,
        output my_turn,
        input  tx_busy
    );

    // The delay line waits for its turn and reports when it sends.
    modport dline (
        input  my_turn,
        output tx_busy
    );

    // The mux only needs to know when to send the BEACON encoding.
    modport mux (
        input  beacon
    );

endinterface

// ==== plca_ctrl/plca_ctrl.sv ====
`timescale 1ns/10ps

module plca_ctrl (
    input  logic                           TX_CLK,
    input  logic                           rst_n,
    input  logic                           plca_en,
    input  logic [plca_pkg::NODE_ID_W-1:0] local_node_id,
    input  logic [plca_pkg::NODE_ID_W-1:0] node_count,
    input  plca_pkg::mii_word_u            rx_word,
    input  logic                           crs,
    txop_if.ctrl                           txop
);
    import plca_pkg::*;

    logic [ST_W-1:0]      state;                      // Opportunity FSM state.
    logic [TIMER_W-1:0]   timer;                      // Shared BEACON and opportunity timer.
    logic [NODE_ID_W-1:0] cur_id;                     // Running opportunity number.
    logic                 coordinator;
    logic                 rx_beacon;
    logic                 rx_commit;
    logic                 carrier;
    logic                 last_opp;
    logic                 opp_end;

    assign coordinator = (local_node_id == '0);                   // Node 0 runs the cycle.
    assign rx_beacon   = (rx_word.code == BEACON_IND);            // Whole-word compare.
    assign rx_commit   = (rx_word.code == COMMIT_IND);            // Another node holds its slot.

    // Anything on the medium or from our own delay line keeps the opportunity open.
    assign carrier = crs | txop.tx_busy | rx_commit | rx_word.f.en;

    // The coordinator wraps after node_count opportunities.
    // A follower stops at the top ID and waits for the next BEACON.
    assign last_opp = coordinator ? (cur_id == node_count - 1'b1) : (cur_id == '1);

    always_comb
    begin
        opp_end = 1'b0;
        if (state == ST_OPP_BUSY)
        begin
            opp_end = !carrier;                       // Ends on the first quiet cycle.
        end
        else if (state == ST_OPP)
        begin
            opp_end = !carrier && (timer == TO_CYCLES - 1); // Idle slot runs out.
        end
    end

    always_ff @(posedge TX_CLK or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state  <= ST_IDLE;
            timer  <= '0;
            cur_id <= '0;
        end
        else if (!plca_en)
        begin
            state  <= ST_IDLE;                        // PLCA off parks the FSM.
            timer  <= '0;
            cur_id <= '0;
        end
        else
        begin
            case (state)
                ST_IDLE:
                begin
                    timer <= '0;
                    state <= coordinator ? ST_BEACON : ST_WAIT_BCN; // BEACON on the first edge.
                end
                ST_BEACON:
                begin
                    if (timer == BEACON_CYCLES - 1)
                    begin
                        state  <= ST_OPP;             // Opportunity 0 follows the BEACON.
                        timer  <= '0;
                        cur_id <= '0;
                    end
                    else
                    begin
                        timer <= timer + 1'b1;
                    end
                end
                ST_WAIT_BCN:
                begin
                    if (rx_beacon)
                    begin
                        state <= ST_RX_BCN;
                    end
                end
                ST_RX_BCN:
                begin
                    if (!rx_beacon)
                    begin
                        state  <= ST_OPP;             // Sync to the end of the BEACON.
                        timer  <= '0;
                        cur_id <= '0;
                    end
                end
                ST_OPP, ST_OPP_BUSY:
                begin
                    if (!coordinator && rx_beacon)
                    begin
                        state <= ST_RX_BCN;           // A fresh BEACON resyncs a follower.
                    end
                    else if (opp_end)
                    begin
                        timer <= '0;
                        if (!last_opp)
                        begin
                            cur_id <= cur_id + 1'b1;
                            state  <= ST_OPP;
                        end
                        else
                        begin
                            state <= coordinator ? ST_BEACON : ST_WAIT_BCN;
                        end
                    end
                    else if (carrier)
                    begin
                        state <= ST_OPP_BUSY;         // Slot taken, timer no longer matters.
                    end
                    else
                    begin
                        timer <= timer + 1'b1;
                    end
                end
                default:
                begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    assign txop.cur_id = cur_id;
    assign txop.beacon = (state == ST_BEACON);

    // The last idle cycle of our slot is withheld so that a drain never starts
    // on a cycle the slot cannot cover. An already running drain keeps it.
    assign txop.my_turn = (cur_id == local_node_id)
                        && ((state == ST_OPP_BUSY)
                            || ((state == ST_OPP)
                                && ((timer != TO_CYCLES - 1) || txop.tx_busy)));

    a_turn_not_beacon : assert property (@(posedge TX_CLK) disable iff (!rst_n)
        !(txop.my_turn && txop.beacon))
        else $error("my_turn and beacon are high together.");

endmodule

// ==== delay_line/plca_delay_line.sv ====
`timescale 1ns/10ps

module plca_delay_line (
    input  logic                          TX_CLK,
    input  logic                          rst_n,
    input  logic                          plca_en,
    input  logic [plca_pkg::NIBBLE_W-1:0] mac_txd,
    input  logic                          mac_txen,
    txop_if.dline                         txop,
    output logic [plca_pkg::NIBBLE_W-1:0] dl_txd,
    output logic                          dl_valid,
    output logic                          pkt_pending
);
    import plca_pkg::*;

    logic [NIBBLE_W-1:0]     mem [DELAY_DEPTH];       // Nibble storage.
    logic [DELAY_ADDR_W-1:0] wr_ptr;
    logic [DELAY_ADDR_W-1:0] rd_ptr;
    logic [DELAY_ADDR_W:0]   level;                   // Nibbles stored and not yet read.
    logic                    full;
    logic                    wr_en;
    logic                    rd_en;
    logic                    start;
    logic                    tx_busy;

    assign full  = (level == DELAY_DEPTH);
    assign wr_en = plca_en && mac_txen && !full;      // Nibbles past the depth are lost.

    // A waiting packet goes out once our turn is seen.
    assign start = plca_en && txop.my_turn && pkt_pending && !tx_busy;

    // One read per cycle from the start until the buffer runs dry.
    // Reads trail writes by at least a cycle, so a live packet never runs dry early.
    assign rd_en = (start || dl_valid) && (level != '0);

    always_ff @(posedge TX_CLK)
    begin
        if (wr_en)
        begin
            mem[wr_ptr] <= mac_txd;
        end
    end

    always_ff @(posedge TX_CLK)
    begin
        if (rd_en)
        begin
            dl_txd <= mem[rd_ptr];                    // Qualified by dl_valid downstream.
        end
    end

    always_ff @(posedge TX_CLK or negedge rst_n)
    begin
        if (!rst_n)
        begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            level       <= '0;
            dl_valid    <= 1'b0;
            tx_busy     <= 1'b0;
            pkt_pending <= 1'b0;
        end
        else if (!plca_en)
        begin
            wr_ptr      <= '0;                        // Bypass leaves the buffer empty.
            rd_ptr      <= '0;
            level       <= '0;
            dl_valid    <= 1'b0;
            tx_busy     <= 1'b0;
            pkt_pending <= 1'b0;
        end
        else
        begin
            if (wr_en)
            begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en)
            begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10:   level <= level + 1'b1;
                2'b01:   level <= level - 1'b1;
                default: level <= level;              // Both or neither leave it unchanged.
            endcase
            dl_valid <= rd_en;
            tx_busy  <= start || dl_valid;            // Covers one cycle past the last nibble.
            if (wr_en && !tx_busy)
            begin
                pkt_pending <= 1'b1;                  // First nibble of a packet is in.
            end
            else if (tx_busy && !dl_valid)
            begin
                pkt_pending <= 1'b0;                  // Drops together with tx_busy.
            end
        end
    end

    assign txop.tx_busy = tx_busy;

    a_no_overflow : assert property (@(posedge TX_CLK) disable iff (!rst_n)
        (plca_en && mac_txen) |-> !full)
        else $error("Delay line overflow. A MAC nibble was dropped.");

    a_drain_in_turn : assert property (@(posedge TX_CLK) disable iff (!rst_n)
        dl_valid |-> txop.my_turn)
        else $error("Delay line presents data outside its opportunity.");

endmodule

// ==== verilog/plca_tx_mux.sv ====
`timescale 1ns/10ps

module plca_tx_mux (
    input  logic                          TX_CLK,
    input  logic                          rst_n,
    input  logic                          plca_en,
    txop_if.mux                           txop,
    input  logic [plca_pkg::NIBBLE_W-1:0] dl_txd,
    input  logic                          dl_valid,
    input  logic [plca_pkg::NIBBLE_W-1:0] mac_txd,
    input  logic                          mac_txen,
    output logic [plca_pkg::NIBBLE_W-1:0] txd,
    output logic                          tx_en,
    output logic                          tx_er
);
    import plca_pkg::*;

    mii_word_u nxt_word;                              // Selected word for the next cycle.
    mii_word_u out_word;                              // Registered MII outputs.

    always_comb
    begin
        nxt_word = '0;
        if (!plca_en)
        begin
            nxt_word.f.en  = mac_txen;                // Straight MAC pass-through.
            nxt_word.f.nib = mac_txd;
        end
        else if (txop.beacon)
        begin
            nxt_word.f.er  = 1'b1;                    // BEACON goes out with TX_EN low.
            nxt_word.f.nib = BEACON_CODE;
        end
        else
        begin
            nxt_word.f.en  = dl_valid;
            nxt_word.f.nib = dl_valid ? dl_txd : '0;  // Quiet TXD between packets.
        end
    end

    always_ff @(posedge TX_CLK or negedge rst_n)
    begin
        if (!rst_n)
        begin
            out_word <= '0;
        end
        else
        begin
            out_word <= nxt_word;
        end
    end

    assign txd   = out_word.f.nib;
    assign tx_en = out_word.f.en;
    assign tx_er = out_word.f.er;

    a_en_er_excl : assert property (@(posedge TX_CLK) disable iff (!rst_n)
        !(tx_en && tx_er))
        else $error("TX_EN and TX_ER are high together.");

endmodule

// ==== verilog/plca_rs.sv ====
`timescale 1ns/10ps

module plca_rs (
    input  logic                           TX_CLK,
    input  logic                           rst_n,
    input  logic                           plca_en,
    input  logic [plca_pkg::NODE_ID_W-1:0] local_node_id,
    input  logic [plca_pkg::NODE_ID_W-1:0] node_count,
    input  logic [plca_pkg::NIBBLE_W-1:0]  RXD,
    input  logic                           RX_DV,
    input  logic                           RX_ER,
    input  logic                           CRS,
    input  logic [plca_pkg::NIBBLE_W-1:0]  mac_txd,
    input  logic                           mac_txen,
    output logic [plca_pkg::NIBBLE_W-1:0]  TXD,
    output logic                           TX_EN,
    output logic                           TX_ER,
    output logic                           pkt_pending
);
    import plca_pkg::*;

    mii_word_u           rx_word;                     // Received MII word.
    logic [NIBBLE_W-1:0] dl_txd;
    logic                dl_valid;

    txop_if txop ();

    assign rx_word.code = {RX_DV, RX_ER, RXD};        // Same bit order as the field view.

    plca_ctrl plca_ctrl_i (
        .TX_CLK        (TX_CLK),
        .rst_n         (rst_n),
        .plca_en       (plca_en),
        .local_node_id (local_node_id),
        .node_count    (node_count),
        .rx_word       (rx_word),
        .crs           (CRS),
        .txop          (txop.ctrl)
    );

    plca_delay_line plca_delay_line_i (
        .TX_CLK      (TX_CLK),
        .rst_n       (rst_n),
        .plca_en     (plca_en),
        .mac_txd     (mac_txd),
        .mac_txen    (mac_txen),
        .txop        (txop.dline),
        .dl_txd      (dl_txd),
        .dl_valid    (dl_valid),
        .pkt_pending (pkt_pending)
    );

    plca_tx_mux plca_tx_mux_i (
        .TX_CLK   (TX_CLK),
        .rst_n    (rst_n),
        .plca_en  (plca_en),
        .txop     (txop.mux),
        .dl_txd   (dl_txd),
        .dl_valid (dl_valid),
        .mac_txd  (mac_txd),
        .mac_txen (mac_txen),
        .txd      (TXD),
        .tx_en    (TX_EN),
        .tx_er    (TX_ER)
    );

endmodule

// ==== bench/plca_rs_tb.sv ====
`timescale 1ns/10ps

module plca_rs_tb;
    import plca_pkg::*;

    localparam int SEED       = 32'h04bd_6b9c;
    localparam int WAIT_LIMIT = 400;                  // Cycles allowed for TX_EN to rise.

    logic                 TX_CLK;
    logic                 rst_n;
    logic                 plca_en;
    logic [NODE_ID_W-1:0] local_node_id;
    logic [NODE_ID_W-1:0] node_count;
    logic [NIBBLE_W-1:0]  RXD;
    logic                 RX_DV;
    logic                 RX_ER;
    logic                 CRS;
    logic [NIBBLE_W-1:0]  mac_txd;
    logic                 mac_txen;
    logic [NIBBLE_W-1:0]  TXD;
    logic                 TX_EN;
    logic                 TX_ER;
    logic                 pkt_pending;

    logic                 exp_on;                     // Enables the MII output checks.
    logic                 exp_en;
    logic                 exp_er;
    logic [NIBBLE_W-1:0]  exp_txd;
    logic                 pend_on;                    // Enables the pending flag check.
    logic                 exp_pend;
    logic                 hold_off;                   // TX_EN must stay low while set.
    logic                 chk_rst;                    // Outputs must be quiet while set.
    int                   errors;
    int                   pend_errors;
    int                   tests_run;
    int                   tests_failed;
    logic [NIBBLE_W-1:0]  pkt [$];                    // Nibbles sent by the MAC, in order.

    plca_rs plca_rs_i (.*);

    always #5 TX_CLK = ~TX_CLK;

    task automatic next_cycle();
        @(posedge TX_CLK);
        #1;                                           // Inputs change 1 ns after the edge.
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("[FAIL] t=%0t ns %s: got 0x%0h, expected 0x%0h", $time, name, got, exp);
        errors++;
    endtask

    task automatic set_expect(input logic en, input logic er, input logic [NIBBLE_W-1:0] nib);
        exp_on  = 1'b1;
        exp_en  = en;
        exp_er  = er;
        exp_txd = nib;
    endtask

    task automatic finish_test(input string name, input int fails);
        tests_run++;
        if (fails != 0)
        begin
            tests_failed++;
        end
        $display("Test %0d %s: %s (%0d errors)", tests_run, name,
                 (fails == 0) ? "passed" : "failed", fails);
    endtask

    task automatic apply_reset(input logic en, input logic [NODE_ID_W-1:0] id,
                               input logic [NODE_ID_W-1:0] cnt);
        exp_on        = 1'b0;
        pend_on       = 1'b0;
        hold_off      = 1'b0;
        chk_rst       = 1'b1;
        rst_n         = 1'b0;
        plca_en       = en;
        local_node_id = id;
        node_count    = cnt;
        RXD           = '0;
        RX_DV         = 1'b0;
        RX_ER         = 1'b0;
        CRS           = 1'b0;
        mac_txd       = '0;
        mac_txen      = 1'b0;
        repeat (5) @(posedge TX_CLK);
        #1;
        rst_n   = 1'b1;
        chk_rst = 1'b0;
    endtask

    // TX_ER covers the cycles after a BEACON that starts on edge s, one cycle late.
    function automatic logic in_beacon(input int i, input int s);
        return (i >= s + 1) && (i <= s + BEACON_CYCLES);
    endfunction

    a_txd : assert property (@(posedge TX_CLK) exp_on |-> (TXD == exp_txd))
        else report_mismatch("TXD", 32'($sampled(TXD)), 32'(exp_txd));
    a_tx_en : assert property (@(posedge TX_CLK) exp_on |-> (TX_EN == exp_en))
        else report_mismatch("TX_EN", 32'($sampled(TX_EN)), 32'(exp_en));
    a_tx_er : assert property (@(posedge TX_CLK) exp_on |-> (TX_ER == exp_er))
        else report_mismatch("TX_ER", 32'($sampled(TX_ER)), 32'(exp_er));
    a_hold_off : assert property (@(posedge TX_CLK) hold_off |-> !TX_EN)
        else report_mismatch("TX_EN", 32'($sampled(TX_EN)), 32'd0);
    a_reset_quiet : assert property (@(posedge TX_CLK) chk_rst |-> !(TX_EN || TX_ER || pkt_pending))
        else report_mismatch("{TX_EN,TX_ER,pkt_pending}",
                             32'($sampled({TX_EN, TX_ER, pkt_pending})), 32'd0);
    a_pending : assert property (@(posedge TX_CLK) pend_on |-> (pkt_pending == exp_pend))
        else
        begin
            report_mismatch("pkt_pending", 32'($sampled(pkt_pending)), 32'(exp_pend));
            pend_errors++;
        end

    initial
    begin
        int i;
        int j;
        int k;
        int len;
        int second;
        int third;
        int crs_first;
        int waited;
        int base;
        int pbase;
        logic                prev_en;
        logic [NIBBLE_W-1:0] prev_txd;

        TX_CLK       = 1'b0;
        errors       = 0;
        pend_errors  = 0;
        tests_run    = 0;
        tests_failed = 0;
        exp_en       = 1'b0;
        exp_er       = 1'b0;
        exp_txd      = '0;
        exp_pend     = 1'b0;
        void'($urandom(SEED));                        // Seeds the generator for the whole run.

        // Coordinator with four nodes, then the period with and without carrier.
        apply_reset(1'b1, 8'd0, 8'd4);
        j         = 4 + ($urandom() % 8);             // Opportunity cycle where CRS rises.
        k         = 30 + ($urandom() % 20);           // CRS length, long enough to stretch the slot.
        second    = BEACON_CYCLES + 4 * TO_CYCLES;
        third     = second + BEACON_CYCLES + 3 * TO_CYCLES + (j + k + 1);
        crs_first = second + BEACON_CYCLES + TO_CYCLES + j;  // Inside opportunity 1.
        base      = errors;
        for (i = 0; i <= third + BEACON_CYCLES + 4; i++)
        begin
            next_cycle();
            if (in_beacon(i, 0) || in_beacon(i, second) || in_beacon(i, third))
            begin
                set_expect(1'b0, 1'b1, BEACON_CODE);
            end
            else
            begin
                set_expect(1'b0, 1'b0, '0);
            end
            CRS = (i >= crs_first) && (i < crs_first + k);
            if (i == second)
            begin
                finish_test("coordinator beacon", errors - base);
                base = errors;
            end
        end
        finish_test("beacon period", errors - base);

        // Follower with ID 3 gets a BEACON on RX and a packet from the MAC.
        apply_reset(1'b1, 8'd3, 8'd4);
        len = 8 + ($urandom() % 33);
        pkt.delete();
        for (i = 0; i < len; i++)
        begin
            pkt.push_back(4'($urandom()));
        end
        base     = errors;
        pbase    = pend_errors;
        pend_on  = 1'b1;
        exp_pend = 1'b0;
        for (i = 0; i < BEACON_CYCLES; i++)
        begin
            next_cycle();
            {RX_DV, RX_ER, RXD} = {1'b0, 1'b1, BEACON_CODE};
        end
        for (i = 0; i < 3 * TO_CYCLES; i++)
        begin
            next_cycle();
            {RX_DV, RX_ER, RXD} = '0;                 // The BEACON ends at i equal to 0.
            hold_off = 1'b1;
            mac_txen = (i >= 2) && (i < 2 + len);
            mac_txd  = '0;
            if (mac_txen)
            begin
                mac_txd = pkt[i - 2];
            end
            exp_pend = (i >= 3);                      // One cycle after the first nibble.
        end
        next_cycle();
        hold_off = 1'b0;
        waited   = 0;
        while (!TX_EN && (waited < WAIT_LIMIT))
        begin
            next_cycle();
            waited++;
        end
        if (!TX_EN)
        begin
            $display("Timeout: TX_EN never rose for the buffered packet.");
            errors++;
        end
        else
        begin
            for (i = 0; i < len; i++)
            begin
                if (i > 0)
                begin
                    next_cycle();
                end
                set_expect(1'b1, 1'b0, pkt[i]);
            end
            next_cycle();
            set_expect(1'b0, 1'b0, '0);
            exp_pend = 1'b0;                          // Drops together with TX_EN.
            repeat (3) next_cycle();
        end
        exp_on  = 1'b0;
        pend_on = 1'b0;
        finish_test("follower data order", (errors - base) - (pend_errors - pbase));
        finish_test("pending flag", pend_errors - pbase);

        // Bypass with PLCA off.
        apply_reset(1'b0, 8'd0, 8'd4);
        base     = errors;
        prev_en  = 1'b0;
        prev_txd = '0;
        for (i = 0; i < 64; i++)
        begin
            next_cycle();
            set_expect(prev_en, 1'b0, prev_txd);
            mac_txen = 1'($urandom());
            mac_txd  = 4'($urandom());
            prev_en  = mac_txen;
            prev_txd = mac_txd;
        end
        next_cycle();
        set_expect(prev_en, 1'b0, prev_txd);
        mac_txen = 1'b0;
        mac_txd  = '0;
        next_cycle();
        exp_on = 1'b0;
        finish_test("bypass", errors - base);

        $display("Tests run: %0d, tests failed: %0d, check errors: %0d",
                 tests_run, tests_failed, errors);
        if ((errors == 0) && (tests_failed == 0))
        begin
            $display("=== PASS ===");
        end
        else
        begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
common/plca_pkg.sv
common/txop_if.sv
plca_ctrl/plca_ctrl.sv
delay_line/plca_delay_line.sv
verilog/plca_tx_mux.sv
verilog/plca_rs.sv
bench/plca_rs_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module plca_rs_tb \
    -f sources.f -Mdir obj_dir -o plca_rs_tb_sim > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
    cat build.log
    echo "Verilator build failed with status $status."
    exit 1
fi

./obj_dir/plca_rs_tb_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status."
    exit 1
fi

if grep -q "=== FAIL ===" sim.log; then
    echo "Simulation reported failure."
    exit 1
fi
if ! grep -q "=== PASS ===" sim.log; then
    echo "Simulation ended without a result."
    exit 1
fi
exit 0
